/* Makefile */
SRCS := $(shell grep -v '^+' sim.f) include/affine_params.svh

obj_dir/Vaffine_tb: sim.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module affine_tb -f sim.f -o Vaffine_tb

run: obj_dir/Vaffine_tb
	./obj_dir/Vaffine_tb | tee sim.log
	! grep -q "Verification failed" sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* design/affine_ctrl.sv */
`include "affine_params.svh"

module affine_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load,
  input  logic                   load_done,
  input  logic                   req_valid,
  input  affine_pkg::point_req_t req,
  output logic                   req_credit,
  input  logic                   res_credit,
  output logic                   issue,
  output affine_pkg::point_req_t issue_req
);
  import affine_pkg::*;

  localparam int QW = $clog2(`REQ_CREDITS);
  localparam int CW = $clog2(`RES_CREDITS + 1);

  ctrl_state_t   state;
  ctrl_state_t   state_nxt;
  point_req_t    q_mem [`REQ_CREDITS];
  logic [QW-1:0] wr_ptr;
  logic [QW-1:0] rd_ptr;
  logic [QW:0]   q_cnt;
  logic [CW-1:0] res_cnt; // Result slots the consumer still has free

  function automatic logic [QW-1:0] ptr_inc(input logic [QW-1:0] p);
    return (p == QW'(`REQ_CREDITS - 1)) ? '0 : p + 1'b1;
  endfunction

  always_comb begin
    state_nxt = state;
    case (state)
      CS_IDLE: if (load) state_nxt = CS_LOAD;
      CS_LOAD: if (load_done) state_nxt = CS_RUN;
      CS_RUN:  if (load && !load_done) state_nxt = CS_LOAD; // Fresh batch
      default: state_nxt = CS_IDLE;
    endcase
  end

  assign issue     = (state == CS_RUN) && (q_cnt != '0) && (res_cnt != '0);
  assign issue_req = q_mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= CS_IDLE;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      q_cnt      <= '0;
      res_cnt    <= CW'(`RES_CREDITS);
      req_credit <= 1'b0;
    end else begin
      state      <= state_nxt;
      req_credit <= issue; // Queue slot freed, hand the credit back
      if (req_valid) wr_ptr <= ptr_inc(wr_ptr);
      if (issue) rd_ptr <= ptr_inc(rd_ptr);
      case ({req_valid, issue})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: ;
      endcase
      case ({res_credit, issue})
        2'b10:   res_cnt <= res_cnt + 1'b1;
        2'b01:   res_cnt <= res_cnt - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      q_mem[wr_ptr] <= req;
    end
  end

endmodule

/* design/affine_pkg.sv */
package affine_pkg;

  `include "affine_params.svh"

  typedef logic signed [`DATA_LEN-1:0] elem_t;

  // Nine elements per memory word, element 0 in the low bits
  typedef elem_t [8:0] coef_word_t;

  typedef struct packed {
    logic       en;
    logic [5:0] addr;
    coef_word_t word;
  } coef_wr_t;

  typedef struct packed {
    logic [4:0] mat;  // Matrix index 0..31
    logic [3:0] tag;
    elem_t      x;
    elem_t      y;
    elem_t      z;
  } point_req_t;

  typedef struct packed {
    logic [3:0]                 tag;
    logic signed [`RES_LEN-1:0] r0;
    logic signed [`RES_LEN-1:0] r1;
    logic signed [`RES_LEN-1:0] r2;
  } point_res_t;

  typedef enum logic [1:0] {
    CS_IDLE,
    CS_LOAD,
    CS_RUN
  } ctrl_state_t;

endpackage

/* design/affine_store.sv */
`include "affine_params.svh"

module affine_store (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               load,
  input  logic [`MAT_COUNT*12*`DATA_LEN-1:0] coef_in,
  output affine_pkg::coef_wr_t               wr,
  output logic                               load_done
);
  import affine_pkg::*;

  localparam int HALF_ELEMS = `MAT_COUNT / 2 * 12; // 192 elements per half
  localparam int FULL_WORDS = HALF_ELEMS / 9;
  localparam int TAIL_ELEMS = HALF_ELEMS % 9;      // Short word 21 holds these

  logic       armed;  // Next edge with load high starts a walk
  logic       wr_en;
  logic [5:0] cnt;
  logic [5:0] nxt_addr;
  logic [8:0] base;
  coef_word_t word_sel;
  coef_word_t wr_word;

  assign nxt_addr = armed ? 6'd0 : cnt + 6'd1;

  // Upper half of memory takes matrices 16..31
  assign base = (nxt_addr[5] ? 9'(HALF_ELEMS) : 9'd0) + 9'(nxt_addr[4:0]) * 9'd9;

  always_comb begin
    word_sel = '0;
    if (nxt_addr[4:0] < 5'(FULL_WORDS)) begin
      word_sel = coef_in[base*`DATA_LEN +: 9*`DATA_LEN];
    end else if (nxt_addr[4:0] == 5'(FULL_WORDS)) begin
      word_sel[TAIL_ELEMS-1:0] = coef_in[base*`DATA_LEN +: TAIL_ELEMS*`DATA_LEN];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      armed     <= 1'b1;
      wr_en     <= 1'b0;
      cnt       <= '0;
      load_done <= 1'b0;
    end else if (!load) begin
      armed     <= 1'b1;
      wr_en     <= 1'b0;
      cnt       <= '0;
      load_done <= 1'b0;
    end else if (armed) begin
      armed <= 1'b0;
      wr_en <= 1'b1;
      cnt   <= nxt_addr;
    end else if (wr_en) begin
      if (cnt == 6'(`COEF_DEPTH - 1)) begin
        wr_en <= 1'b0; // Last word goes out on this edge
      end else begin
        cnt <= nxt_addr;
      end
    end else begin
      load_done <= 1'b1;
    end
  end

  // Tracks cnt since both advance to nxt_addr together
  always_ff @(posedge clk) begin
    wr_word <= word_sel;
  end

  assign wr = '{en: wr_en, addr: cnt, word: wr_word};

endmodule

/* design/affine_top.sv */
`include "affine_params.svh"

module affine_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               load,
  input  logic [`MAT_COUNT*12*`DATA_LEN-1:0] coef_in,
  output logic                               load_done,
  input  logic                               req_valid,
  input  affine_pkg::point_req_t             req,
  output logic                               req_credit,
  output logic                               res_valid,
  output affine_pkg::point_res_t             res,
  input  logic                               res_credit
);
  import affine_pkg::*;

  coef_wr_t   wr;
  logic       issue;
  point_req_t issue_req;
  logic [5:0] rd_addr_a;
  logic [5:0] rd_addr_b;
  coef_word_t rd_a;
  coef_word_t rd_b;

  affine_store u_store (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .coef_in   (coef_in),
    .wr        (wr),
    .load_done (load_done)
  );

  coef_ram u_ram (
    .clk       (clk),
    .wr        (wr),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_a      (rd_a),
    .rd_b      (rd_b)
  );

  affine_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (load),
    .load_done  (load_done),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .res_credit (res_credit),
    .issue      (issue),
    .issue_req  (issue_req)
  );

  point_transform u_xform (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (issue),
    .issue_req (issue_req),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_a      (rd_a),
    .rd_b      (rd_b),
    .res_valid (res_valid),
    .res       (res)
  );

endmodule

/* design/coef_ram.sv */
`include "affine_params.svh"

module coef_ram (
  input  logic                   clk,
  input  affine_pkg::coef_wr_t   wr,
  input  logic [5:0]             rd_addr_a,
  input  logic [5:0]             rd_addr_b,
  output affine_pkg::coef_word_t rd_a,
  output affine_pkg::coef_word_t rd_b
);
  import affine_pkg::*;

  coef_word_t mem [`COEF_DEPTH];

  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.word;
    end
  end

  // Two read ports so a matrix spanning a word boundary arrives at once
  always_ff @(posedge clk) begin
    rd_a <= mem[rd_addr_a];
    rd_b <= mem[rd_addr_b];
  end

endmodule

/* design/point_transform.sv */
`include "affine_params.svh"

module point_transform (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   issue,
  input  affine_pkg::point_req_t issue_req,
  output logic [5:0]             rd_addr_a,
  output logic [5:0]             rd_addr_b,
  input  affine_pkg::coef_word_t rd_a,
  input  affine_pkg::coef_word_t rd_b,
  output logic                   res_valid,
  output affine_pkg::point_res_t res
);
  import affine_pkg::*;

  logic [7:0]                   e_off; // 12 * (mat mod 16)
  logic                         s1_valid;
  point_req_t                   s1_req;
  logic [3:0]                   s1_off;
  elem_t [17:0]                 pair;
  logic                         s2_valid;
  logic [3:0]                   s2_tag;
  logic signed [2*`DATA_LEN-1:0] prod [3][4];
  logic signed [`RES_LEN-1:0]   row_sum [3];

  assign e_off     = 8'(issue_req.mat[3:0]) * 8'd12;
  assign rd_addr_a = {issue_req.mat[4], 5'(e_off / 8'd9)};
  assign rd_addr_b = rd_addr_a + 6'd1;

  // Read data lines up with stage 1, word b on top
  assign pair = {rd_b, rd_a};

  always_comb begin
    for (int r = 0; r < 3; r++) begin
      row_sum[r] = prod[r][0] + prod[r][1] + prod[r][2] + prod[r][3];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      s1_valid  <= issue;
      s2_valid  <= s1_valid;
      res_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_req <= issue_req;
    s1_off <= 4'(e_off % 8'd9); // 0, 3 or 6
    s2_tag <= s1_req.tag;
    for (int r = 0; r < 3; r++) begin
      prod[r][0] <= $signed(pair[s1_off + 4*r])     * s1_req.x;
      prod[r][1] <= $signed(pair[s1_off + 4*r + 1]) * s1_req.y;
      prod[r][2] <= $signed(pair[s1_off + 4*r + 2]) * s1_req.z;
      prod[r][3] <= $signed(pair[s1_off + 4*r + 3]); // Translation term
    end
    res.tag <= s2_tag;
    res.r0  <= row_sum[0];
    res.r1  <= row_sum[1];
    res.r2  <= row_sum[2];
  end

endmodule

/* include/affine_params.svh */
`ifndef AFFINE_PARAMS_SVH
`define AFFINE_PARAMS_SVH

// Element and coordinate width
`define DATA_LEN 16

// Matrices per batch, 3x4 each
`define MAT_COUNT 32

`define COEF_DEPTH 64

// Request queue depth, also the credits a requester starts with
`define REQ_CREDITS 2

`define RES_CREDITS 4 // Result slots granted at reset

// Full product width plus growth for the four-term row sum
`define RES_LEN (2*`DATA_LEN+2)

`endif

/* sim.f */
+incdir+include
design/affine_pkg.sv
design/affine_store.sv
design/coef_ram.sv
design/affine_ctrl.sv
design/point_transform.sv
design/affine_top.sv
testbench/affine_tb.sv

/* testbench/affine_tb.sv */
`include "affine_params.svh"

module affine_tb;
  import affine_pkg::*;

  localparam int NUM_TESTS = 6;

  logic                               clk = 1'b0;
  logic                               rst_n = 1'b0;
  logic                               load = 1'b0;
  logic [`MAT_COUNT*12*`DATA_LEN-1:0] coef_in = '0;
  logic                               load_done;
  logic                               req_valid = 1'b0;
  point_req_t                         req = '0;
  logic                               req_credit;
  logic                               res_valid;
  point_res_t                         res;
  logic                               res_credit = 1'b0;

  logic signed [`DATA_LEN-1:0] mats [`MAT_COUNT][12]; // Reference copy of the batch
  point_res_t  exp_q [$];
  logic [31:0] seed = 32'h1c1a_c262;
  int credits = `REQ_CREDITS; // Requester side view
  int credit_pulses = 0;
  int sent = 0;
  int rx_count = 0;
  int pending = 0;            // Results held by the consumer
  bit hold = 1'b0;
  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  affine_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (load),
    .coef_in    (coef_in),
    .load_done  (load_done),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .res_valid  (res_valid),
    .res        (res),
    .res_credit (res_credit)
  );

  always #50 clk = ~clk;

  initial begin
    #(20000 * NUM_TESTS);
    $display("Watchdog timeout, the tests did not finish in time");
    $display("Verification failed");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic signed [`DATA_LEN-1:0] rand_elem();
    logic [31:0] v;
    v = lcg_next();
    return {{(`DATA_LEN-8){v[23]}}, v[23:16]}; // 8-bit signed range
  endfunction

  function automatic point_req_t rand_point(input int mat, input int tag);
    point_req_t p;
    p.mat = 5'(mat);
    p.tag = 4'(tag);
    p.x   = rand_elem();
    p.y   = rand_elem();
    p.z   = rand_elem();
    return p;
  endfunction

  // Each row dotted with (x, y, z, 1)
  function automatic point_res_t calc_result(input point_req_t p);
    point_res_t r;
    longint     acc [3];
    for (int i = 0; i < 3; i++) begin
      acc[i] = longint'(mats[p.mat][4*i]) * p.x + longint'(mats[p.mat][4*i+1]) * p.y
             + longint'(mats[p.mat][4*i+2]) * p.z + longint'(mats[p.mat][4*i+3]);
    end
    r.tag = p.tag;
    r.r0  = `RES_LEN'(acc[0]);
    r.r1  = `RES_LEN'(acc[1]);
    r.r2  = `RES_LEN'(acc[2]);
    return r;
  endfunction

  always @(negedge clk) begin
    point_res_t e;
    if (rst_n && res_valid) begin
      rx_count++;
      pending++;
      if (exp_q.size() == 0) begin
        $display("Result with tag %0d arrived with no request outstanding", res.tag);
        errors++;
      end else begin
        e = exp_q.pop_front();
        if (res !== e) begin
          $display("[ERROR] %0t: got tag %0d (%0d %0d %0d), expected tag %0d (%0d %0d %0d)",
                   $time, res.tag, res.r0, res.r1, res.r2, e.tag, e.r0, e.r1, e.r2);
          errors++;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && req_credit) begin
      credits++;
      credit_pulses++;
      if (credits > `REQ_CREDITS) begin
        $display("[ERROR] %0t: requester holds %0d credits, more than granted", $time, credits);
        errors++;
      end
    end
  end

  // Consumer frees one result slot per cycle unless held back
  always @(posedge clk) begin
    #10;
    if (!hold && pending > 0) begin
      res_credit = 1'b1;
      pending--;
    end else begin
      res_credit = 1'b0;
    end
  end

  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic send_req(input point_req_t p);
    while (credits == 0) begin
      step();
    end
    req_valid = 1'b1;
    req       = p;
    credits--;
    exp_q.push_back(calc_result(p));
    sent++;
    step();
    req_valid = 1'b0;
  endtask

  // Every expected result seen and every held slot handed back
  task automatic wait_idle();
    while (exp_q.size() != 0 || pending != 0) begin
      step();
    end
  endtask

  task automatic load_batch();
    int n;
    for (int m = 0; m < `MAT_COUNT; m++) begin
      for (int k = 0; k < 12; k++) begin
        mats[m][k] = rand_elem();
        coef_in[(m*12+k)*`DATA_LEN +: `DATA_LEN] = mats[m][k];
      end
    end
    load = 1'b1;
    n = 0;
    step();
    while (!load_done && n < 200) begin
      step();
      n++;
    end
    if (!load_done) begin
      $display("load_done did not rise within 200 cycles of load");
      errors++;
    end
    load = 1'b0;
    step();
  endtask

  task automatic check_count(input int got, input int want, input string what);
    if (got != want) begin
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      $display("PASS %s", name);
      tests_passed++;
    end else begin
      $display("[ERROR] %0t: test %s saw %0d errors", $time, name, errors - err0);
      tests_failed++;
    end
  endtask

  task automatic reset_values();
    int err0;
    err0 = errors;
    if (res_valid !== 1'b0 || req_credit !== 1'b0 || load_done !== 1'b0) begin
      $display("[ERROR] %0t: after reset res_valid %b req_credit %b load_done %b, expected 0",
               $time, res_valid, req_credit, load_done);
      errors++;
    end
    report_test("reset", err0);
  endtask

  task automatic single_point();
    int err0;
    int rx0;
    err0 = errors;
    load_batch();
    rx0 = rx_count;
    send_req(rand_point(0, 5));
    wait_idle();
    check_count(rx_count - rx0, 1, "results for one point");
    report_test("single point", err0);
  endtask

  task automatic all_matrices();
    int err0;
    int rx0;
    err0 = errors;
    rx0 = rx_count;
    for (int m = 0; m < `MAT_COUNT; m++) begin
      send_req(rand_point(m, m));
    end
    wait_idle();
    check_count(rx_count - rx0, `MAT_COUNT, "results for all matrices");
    report_test("all matrices", err0);
  endtask

  task automatic result_backpressure();
    int err0;
    int rx0;
    err0 = errors;
    rx0 = rx_count;
    hold = 1'b1;
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          send_req(rand_point(31 - 3 * i, i));
        end
      end
      begin
        repeat (30) @(posedge clk);
        check_count(rx_count - rx0, `RES_CREDITS, "results while credits withheld");
        check_count(credits, 0, "requester credits while stalled");
        hold = 1'b0;
      end
    join
    wait_idle();
    check_count(rx_count - rx0, 8, "results after credits returned");
    report_test("result back-pressure", err0);
  endtask

  task automatic request_credits();
    int err0;
    err0 = errors;
    for (int i = 0; i < 10; i++) begin
      send_req(rand_point(i * 7 % `MAT_COUNT, i));
    end
    wait_idle();
    check_count(credit_pulses, sent, "req_credit pulses");
    check_count(credits, `REQ_CREDITS, "requester credits when idle");
    report_test("request credits", err0);
  endtask

  task automatic reload_matrices();
    int err0;
    int rx0;
    err0 = errors;
    load_batch();
    rx0 = rx_count;
    for (int i = 0; i < 8; i++) begin
      send_req(rand_point(i * 5 % `MAT_COUNT, i + 8));
    end
    wait_idle();
    check_count(rx_count - rx0, 8, "results after reload");
    report_test("reload", err0);
  endtask

  initial begin
    repeat (2) @(posedge clk);
    #10;
    rst_n = 1'b1;
    reset_values();
    single_point();
    all_matrices();
    result_backpressure();
    request_credits();
    reload_matrices();
    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
